// ==== Bender.yml ====
package:
  name: rename_core

sources:
  # shared package first
  - src/rename_pkg.sv
  # datapath and control
  - src/prf.sv
  - src/map_table.sv
  - src/free_list.sv
  - src/rename_ctrl.sv
  # top level
  - src/rename_core.sv
  - target: simulation
    files:
      - sim/rename_core_chk.sv
      - sim/rename_core_tb.sv

// ==== sim/rename_core_chk.sv ====
`timescale 1ns/10ps
`default_nettype none

module rename_core_chk (
    input logic                                           clock,
    input logic                                           reset,
    input logic                                           rename_valid,
    input logic                                           rename_ready,
    input rename_pkg::arn_t  [rename_pkg::n_ways-1:0]     dest_arn,
    input rename_pkg::prn_t  [rename_pkg::n_ways-1:0]     dest_prn,
    input rename_pkg::free_cnt_t                          free_count
);

    logic accept;

    assign accept = rename_valid && rename_ready;

    count_in_range: assert property (
        @(posedge clock) disable iff (reset)
        free_count <= rename_pkg::free_cnt_t'(rename_pkg::free_depth)
    ) else $error("free list holds more entries than its capacity");

    // a stalled group must not consume free prns
    no_pop_when_stalled: assert property (
        @(posedge clock) disable iff (reset)
        !rename_ready |=> free_count >= $past(free_count)
    ) else $error("free list shrank after a cycle with rename_ready low");

    dest0_allocated: assert property (
        @(posedge clock) disable iff (reset)
        accept && dest_arn[0] != '0 |->
            dest_prn[0] != '0 && dest_prn[0] < rename_pkg::prn_t'(rename_pkg::phys_reg_sz)
    ) else $error("instruction 0 got no usable destination prn");

    dest1_allocated: assert property (
        @(posedge clock) disable iff (reset)
        accept && dest_arn[1] != '0 |->
            dest_prn[1] != '0 && dest_prn[1] < rename_pkg::prn_t'(rename_pkg::phys_reg_sz)
    ) else $error("instruction 1 got no usable destination prn");

endmodule

bind rename_core rename_core_chk u_chk (
    .clock        (clock),
    .reset        (reset),
    .rename_valid (rename_valid),
    .rename_ready (rename_ready),
    .dest_arn     (dest_arn),
    .dest_prn     (dest_prn),
    .free_count   (free_count)
);

`default_nettype wire

// ==== sim/rename_core_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module rename_core_tb;

    localparam int n_pat      = 16;
    localparam int pat_w      = 316;
    // free-list fill, the patterns and slack for reset
    localparam int max_cycles = rename_pkg::free_depth + n_pat + 20;

    logic clock;
    logic reset;

    logic                                           rename_valid;
    logic                                           rename_ready;
    rename_pkg::arn_t  [2*rename_pkg::n_ways-1:0]   src_arn;
    rename_pkg::arn_t  [rename_pkg::n_ways-1:0]     dest_arn;
    rename_pkg::prn_t  [2*rename_pkg::n_ways-1:0]   src_prn;
    rename_pkg::prn_t  [rename_pkg::n_ways-1:0]     dest_prn;
    rename_pkg::prn_t  [rename_pkg::n_ways-1:0]     old_prn;
    rename_pkg::prn_t  [rename_pkg::n_ways-1:0]     write_prn;
    rename_pkg::data_t [rename_pkg::n_ways-1:0]     write_data;
    rename_pkg::prn_t  [rename_pkg::n_ways-1:0]     commit_prn;
    rename_pkg::prn_t  [2*rename_pkg::n_ways-1:0]   read_prn;
    rename_pkg::data_t [2*rename_pkg::n_ways-1:0]   read_data;
    logic              [2*rename_pkg::n_ways-1:0]   read_valid;
    rename_pkg::prn_t  [rename_pkg::n_ways-1:0]     wb_read_prn;
    rename_pkg::data_t [rename_pkg::n_ways-1:0]     wb_data;

    logic [pat_w-1:0] patterns [n_pat];

    // expected values of the pattern under test
    logic                                           exp_ready;
    rename_pkg::prn_t  [2*rename_pkg::n_ways-1:0]   exp_src;
    rename_pkg::prn_t  [rename_pkg::n_ways-1:0]     exp_dest;
    rename_pkg::prn_t  [rename_pkg::n_ways-1:0]     exp_old;
    rename_pkg::data_t [2*rename_pkg::n_ways-1:0]   exp_rdata;
    logic              [2*rename_pkg::n_ways-1:0]   exp_rvalid;
    rename_pkg::data_t [rename_pkg::n_ways-1:0]     exp_wb;
    logic              [7:0]                        exp_mask;

    int cycle_count;

    rename_core u_dut (
        .clock        (clock),
        .reset        (reset),
        .rename_valid (rename_valid),
        .rename_ready (rename_ready),
        .src_arn      (src_arn),
        .dest_arn     (dest_arn),
        .src_prn      (src_prn),
        .dest_prn     (dest_prn),
        .old_prn      (old_prn),
        .write_prn    (write_prn),
        .write_data   (write_data),
        .commit_prn   (commit_prn),
        .read_prn     (read_prn),
        .read_data    (read_data),
        .read_valid   (read_valid),
        .wb_read_prn  (wb_read_prn),
        .wb_data      (wb_data)
    );

    always #4 clock = ~clock;

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > max_cycles) begin
            fail_run($sformatf("Timeout, the run did not end within %0d cycles", max_cycles));
        end
    end

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("CHECKS FAILED");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic report_mismatch(input int idx, input string field,
                                   input logic [63:0] expected, input logic [63:0] actual);
        fail_run($sformatf("Mismatch in pattern %0d, %s expected %0h actual %0h",
                           idx, field, expected, actual));
    endtask

    task automatic idle_inputs();
        rename_valid = 1'b0;
        src_arn      = '0;
        dest_arn     = '0;
        write_prn    = '0;
        write_data   = '0;
        commit_prn   = '0;
        read_prn     = '0;
        wb_read_prn  = '0;
    endtask

    // index 0 of each group is the leftmost field of a line
    task automatic apply_line(input int idx);
        logic [pat_w-1:0] word;
        int               pos;
        word = patterns[idx];
        pos  = pat_w - 4;
        rename_valid = word[pos];
        for (int i = 0; i < 4; i++) begin
            pos -= 4;
            src_arn[i] = word[pos +: 3];
        end
        for (int k = 0; k < 2; k++) begin
            pos -= 4;
            dest_arn[k] = word[pos +: 3];
        end
        for (int k = 0; k < 2; k++) begin
            pos -= 8;
            write_prn[k] = word[pos +: 5];
        end
        for (int k = 0; k < 2; k++) begin
            pos -= 16;
            write_data[k] = word[pos +: 16];
        end
        for (int k = 0; k < 2; k++) begin
            pos -= 8;
            commit_prn[k] = word[pos +: 5];
        end
        for (int i = 0; i < 4; i++) begin
            pos -= 8;
            read_prn[i] = word[pos +: 5];
        end
        for (int k = 0; k < 2; k++) begin
            pos -= 8;
            wb_read_prn[k] = word[pos +: 5];
        end
        // expected half of the line
        pos -= 4;
        exp_ready = word[pos];
        for (int i = 0; i < 4; i++) begin
            pos -= 8;
            exp_src[i] = word[pos +: 5];
        end
        for (int k = 0; k < 2; k++) begin
            pos -= 8;
            exp_dest[k] = word[pos +: 5];
        end
        for (int k = 0; k < 2; k++) begin
            pos -= 8;
            exp_old[k] = word[pos +: 5];
        end
        for (int i = 0; i < 4; i++) begin
            pos -= 16;
            exp_rdata[i] = word[pos +: 16];
        end
        pos -= 4;
        exp_rvalid = word[pos +: 4];
        for (int k = 0; k < 2; k++) begin
            pos -= 16;
            exp_wb[k] = word[pos +: 16];
        end
        pos -= 8;
        exp_mask = word[pos +: 8];
    endtask

    task automatic check_outputs(input int idx);
        if (exp_mask[0]) begin
            assert (rename_ready === exp_ready)
                else report_mismatch(idx, "rename_ready", 64'(exp_ready), 64'(rename_ready));
        end
        for (int i = 0; i < 4; i++) begin
            if (exp_mask[1]) begin
                assert (src_prn[i] === exp_src[i])
                    else report_mismatch(idx, $sformatf("src_prn[%0d]", i),
                                         64'(exp_src[i]), 64'(src_prn[i]));
            end
            if (exp_mask[4]) begin
                assert (read_data[i] === exp_rdata[i])
                    else report_mismatch(idx, $sformatf("read_data[%0d]", i),
                                         64'(exp_rdata[i]), 64'(read_data[i]));
            end
        end
        for (int k = 0; k < 2; k++) begin
            if (exp_mask[2]) begin
                assert (dest_prn[k] === exp_dest[k])
                    else report_mismatch(idx, $sformatf("dest_prn[%0d]", k),
                                         64'(exp_dest[k]), 64'(dest_prn[k]));
            end
            if (exp_mask[3]) begin
                assert (old_prn[k] === exp_old[k])
                    else report_mismatch(idx, $sformatf("old_prn[%0d]", k),
                                         64'(exp_old[k]), 64'(old_prn[k]));
            end
            if (exp_mask[6]) begin
                assert (wb_data[k] === exp_wb[k])
                    else report_mismatch(idx, $sformatf("wb_data[%0d]", k),
                                         64'(exp_wb[k]), 64'(wb_data[k]));
            end
        end
        if (exp_mask[5]) begin
            assert (read_valid === exp_rvalid)
                else report_mismatch(idx, "read_valid", 64'(exp_rvalid), 64'(read_valid));
        end
    endtask

    initial begin
        clock       = 1'b0;
        reset       = 1'b1;
        cycle_count = 0;
        idle_inputs();
        $readmemh("sim/rename_patterns.txt", patterns);
        repeat (2) @(posedge clock);
        #1;
        reset = 1'b0;
        // free list fills first, ready marks the end of it
        while (!rename_ready) begin
            @(posedge clock);
            #1;
        end
        for (int n = 0; n < n_pat; n++) begin
            apply_line(n);
            // sample just before the next edge
            #6;
            check_outputs(n);
            @(posedge clock);
            #1;
        end
        idle_inputs();
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/rename_patterns.txt ====
// in: valid src_arn0-3 dest_arn0-1 write_prn0-1 write_data0-1 commit_prn0-1 read_prn0-3 wb_prn0-1
// exp: ready src_prn0-3 dest_prn0-1 old_prn0-1 read_data0-3 read_valid(bit i=port i) wb_data0-1 mask
// mask bits: 0 ready, 1 src_prn, 2 dest_prn, 3 old_prn, 4 read_data, 5 read_valid, 6 wb_data
0_0000_00_0000_00000000_0000_00030708_0007_1_00000000_0000_0000_0000000000000000_7_00000000_71
1_2314_12_0000_00000000_0000_00010708_0008_1_02030804_0809_0102_0000000000000000_7_00000000_7f
1_1210_03_0800_1234beef_0000_08000901_0800_1_08090800_000a_0003_1234000000000000_b_00000000_7f
1_3142_44_090a_56789abc_0000_0800090a_0800_1_0a080b09_0b0c_040b_1234000056789abc_f_12340000_7f
1_4450_50_0b00_0f0f0000_0000_0b090c0d_0a09_1_0c0c0d00_0d00_0500_0f0f567800000000_3_9abc5678_7f
1_1263_67_0000_00000000_0000_0b0d0100_0b0c_1_08090e0a_0e0f_0607_0f0f000000000000_d_0f0f0000_7f
1_1121_12_0000_00000000_0000_0e0f0810_0809_1_08080910_1011_0809_0000000012340000_4_12345678_7f
1_5637_33_0000_00000000_0000_11120a00_0a0b_1_0d0e120f_1213_0a12_000000009abc0000_c_9abc0f0f_7f
1_1234_45_0000_00000000_0000_13020300_0c0d_1_10111314_1415_0c0d_0000000000000000_e_00000000_7f
1_0066_67_0000_00000000_0000_16171415_1617_1_00001616_1617_0e0f_0000000000000000_0_00000000_7f
// free list empty, group held until commits refill it
1_2314_12_0000_00000000_0000_10110809_0809_0_00000000_0000_0000_0000000012345678_c_12345678_71
1_2314_12_1000_22220000_0b04_100b0400_100b_0_00000000_0000_0000_22220f0f00000000_f_00000f0f_71
1_2314_12_0000_00000000_0000_0b100400_100b_1_11130b14_0b04_1011_0f0f222200000000_f_22220f0f_7f
0_0000_00_0000_00000000_0c0d_0b041000_0b04_0_00000000_0000_0000_0f0f000022220000_c_0f0f0000_71
1_1235_35_0b00_33330000_0000_0b040c0d_0b04_1_0b040c15_0c0d_1315_3333000000000000_1_0f0f0000_7f
0_0000_00_0000_00000000_0000_0b0c0d00_0b0c_0_00000000_0000_0000_3333000000000000_9_33330000_71

// ==== src/free_list.sv ====
`timescale 1ns/10ps
`default_nettype none

module free_list (
    input  logic                                            clock,
    input  logic                                            reset,
    input  logic             [1:0]                          pop_count,
    // two oldest free prns
    output rename_pkg::prn_t [rename_pkg::n_ways-1:0]       head_prn,
    // zero means no push on that port
    input  rename_pkg::prn_t [rename_pkg::n_ways-1:0]       push_prn,
    output rename_pkg::free_cnt_t                           count
);

    rename_pkg::prn_t entries [rename_pkg::free_depth];

    logic [rename_pkg::free_ptr_w-1:0] head_q;
    logic [rename_pkg::free_ptr_w-1:0] tail_q;
    logic [rename_pkg::free_ptr_w-1:0] head_next1;
    logic [rename_pkg::free_ptr_w-1:0] tail_next1;
    rename_pkg::free_cnt_t             count_q;

    logic                              push0;
    logic                              push1;
    logic [1:0]                        push_count;

    assign push0      = push_prn[0] != '0;
    assign push1      = push_prn[1] != '0;
    assign push_count = {1'b0, push0} + {1'b0, push1};

    // pointers wrap at free_depth
    assign head_next1 = head_q + 1'b1;
    // port 1 lands after port 0 only when port 0 pushed
    assign tail_next1 = tail_q + {{(rename_pkg::free_ptr_w-1){1'b0}}, push0};

    assign head_prn[0] = entries[head_q];
    assign head_prn[1] = entries[head_next1];
    assign count       = count_q;

    always_ff @(posedge clock) begin
        if (push0) begin
            entries[tail_q] <= push_prn[0];
        end
        if (push1) begin
            entries[tail_next1] <= push_prn[1];
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            head_q  <= head_q + rename_pkg::free_ptr_w'(pop_count);
            tail_q  <= tail_q + rename_pkg::free_ptr_w'(push_count);
            count_q <= count_q - rename_pkg::free_cnt_t'(pop_count)
                               + rename_pkg::free_cnt_t'(push_count);
        end
    end

endmodule

`default_nettype wire

// ==== src/map_table.sv ====
`timescale 1ns/10ps
`default_nettype none

module map_table (
    input  logic                                            clock,
    input  logic                                            reset,
    // source lookups for the whole group
    input  rename_pkg::arn_t [2*rename_pkg::n_ways-1:0]     lookup_arn,
    output rename_pkg::prn_t [2*rename_pkg::n_ways-1:0]     lookup_prn,
    // current mapping of each destination
    input  rename_pkg::arn_t [rename_pkg::n_ways-1:0]       dest_arn,
    output rename_pkg::prn_t [rename_pkg::n_ways-1:0]       dest_old_prn,
    // updates
    input  logic             [rename_pkg::n_ways-1:0]       we,
    input  rename_pkg::arn_t [rename_pkg::n_ways-1:0]       wr_arn,
    input  rename_pkg::prn_t [rename_pkg::n_ways-1:0]       wr_prn
);

    rename_pkg::prn_t map_q [rename_pkg::arch_reg_sz];

    always_comb begin
        for (int i = 0; i < 2 * rename_pkg::n_ways; i++) begin
            lookup_prn[i] = map_q[lookup_arn[i]];
        end
        for (int k = 0; k < rename_pkg::n_ways; k++) begin
            dest_old_prn[k] = map_q[dest_arn[k]];
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            // identity map
            for (int i = 0; i < rename_pkg::arch_reg_sz; i++) begin
                map_q[i] <= rename_pkg::prn_t'(i);
            end
        end else begin
            // port order, so the younger instruction wins
            for (int k = 0; k < rename_pkg::n_ways; k++) begin
                if (we[k] && wr_arn[k] != '0) begin
                    map_q[wr_arn[k]] <= wr_prn[k];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/prf.sv ====
`timescale 1ns/10ps
`default_nettype none

module prf (
    input  logic                                            clock,
    input  logic                                            reset,
    // issue reads
    input  rename_pkg::prn_t  [2*rename_pkg::n_ways-1:0]    read_prn,
    output rename_pkg::data_t [2*rename_pkg::n_ways-1:0]    read_data,
    output logic              [2*rename_pkg::n_ways-1:0]    read_valid,
    // writeback writes
    input  rename_pkg::prn_t  [rename_pkg::n_ways-1:0]      write_prn,
    input  rename_pkg::data_t [rename_pkg::n_ways-1:0]      write_data,
    // newly allocated prns go invalid
    input  rename_pkg::prn_t  [rename_pkg::n_ways-1:0]      invalid_prn,
    // writeback file reads
    input  rename_pkg::prn_t  [rename_pkg::n_ways-1:0]      wb_read_prn,
    output rename_pkg::data_t [rename_pkg::n_ways-1:0]      wb_data
);

    rename_pkg::data_t value_q [rename_pkg::phys_reg_sz];
    logic              valid_q [rename_pkg::phys_reg_sz];

    logic [rename_pkg::n_ways-1:0] write_en;
    logic [rename_pkg::n_ways-1:0] inval_en;

    always_comb begin
        for (int j = 0; j < rename_pkg::n_ways; j++) begin
            write_en[j] = write_prn[j] != '0;
            inval_en[j] = invalid_prn[j] != '0;
        end
    end

    // issue reads with same-cycle write bypass
    always_comb begin
        for (int i = 0; i < 2 * rename_pkg::n_ways; i++) begin
            read_data[i]  = value_q[read_prn[i]];
            read_valid[i] = valid_q[read_prn[i]];
            for (int j = 0; j < rename_pkg::n_ways; j++) begin
                if (write_en[j] && write_prn[j] == read_prn[i]) begin
                    read_data[i]  = write_data[j];
                    read_valid[i] = 1'b1;
                end
            end
            // zero register
            if (read_prn[i] == '0) begin
                read_data[i]  = '0;
                read_valid[i] = 1'b1;
            end
        end
    end

    // writeback file sees stored state only
    always_comb begin
        for (int j = 0; j < rename_pkg::n_ways; j++) begin
            wb_data[j] = value_q[wb_read_prn[j]];
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            // architectural prns start valid, the free pool starts invalid
            for (int i = 0; i < rename_pkg::phys_reg_sz; i++) begin
                value_q[i] <= '0;
                valid_q[i] <= (i < rename_pkg::arch_reg_sz);
            end
        end else begin
            for (int j = 0; j < rename_pkg::n_ways; j++) begin
                if (write_en[j]) begin
                    value_q[write_prn[j]] <= write_data[j];
                    valid_q[write_prn[j]] <= 1'b1;
                end
            end
            // invalidate comes last so it wins over a write to the same prn
            for (int j = 0; j < rename_pkg::n_ways; j++) begin
                if (inval_en[j]) begin
                    valid_q[invalid_prn[j]] <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/rename_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module rename_core (
    input  logic                                            clock,
    input  logic                                            reset,
    // rename group
    input  logic                                            rename_valid,
    output logic                                            rename_ready,
    input  rename_pkg::arn_t  [2*rename_pkg::n_ways-1:0]    src_arn,
    input  rename_pkg::arn_t  [rename_pkg::n_ways-1:0]      dest_arn,
    output rename_pkg::prn_t  [2*rename_pkg::n_ways-1:0]    src_prn,
    output rename_pkg::prn_t  [rename_pkg::n_ways-1:0]      dest_prn,
    output rename_pkg::prn_t  [rename_pkg::n_ways-1:0]      old_prn,
    // writeback and commit
    input  rename_pkg::prn_t  [rename_pkg::n_ways-1:0]      write_prn,
    input  rename_pkg::data_t [rename_pkg::n_ways-1:0]      write_data,
    input  rename_pkg::prn_t  [rename_pkg::n_ways-1:0]      commit_prn,
    // register reads
    input  rename_pkg::prn_t  [2*rename_pkg::n_ways-1:0]    read_prn,
    output rename_pkg::data_t [2*rename_pkg::n_ways-1:0]    read_data,
    output logic              [2*rename_pkg::n_ways-1:0]    read_valid,
    input  rename_pkg::prn_t  [rename_pkg::n_ways-1:0]      wb_read_prn,
    output rename_pkg::data_t [rename_pkg::n_ways-1:0]      wb_data
);

    rename_pkg::prn_t  [2*rename_pkg::n_ways-1:0] map_prn;
    rename_pkg::prn_t  [rename_pkg::n_ways-1:0]   map_old_prn;
    rename_pkg::prn_t  [rename_pkg::n_ways-1:0]   free_head_prn;
    rename_pkg::free_cnt_t                        free_count;
    logic              [rename_pkg::n_ways-1:0]   map_we;
    rename_pkg::arn_t  [rename_pkg::n_ways-1:0]   map_arn;
    rename_pkg::prn_t  [rename_pkg::n_ways-1:0]   map_new_prn;
    logic              [1:0]                      pop_count;
    rename_pkg::prn_t  [rename_pkg::n_ways-1:0]   invalid_prn;
    logic                                         fill_push;
    rename_pkg::prn_t                             fill_prn;
    rename_pkg::prn_t  [rename_pkg::n_ways-1:0]   push_prn;

    // commits are dropped while the free list is being filled
    assign push_prn[0] = fill_push ? fill_prn : commit_prn[0];
    assign push_prn[1] = fill_push ? '0 : commit_prn[1];

    rename_ctrl u_ctrl (
        .clock         (clock),
        .reset         (reset),
        .rename_valid  (rename_valid),
        .src_arn       (src_arn),
        .dest_arn      (dest_arn),
        .map_prn       (map_prn),
        .map_old_prn   (map_old_prn),
        .free_head_prn (free_head_prn),
        .free_count    (free_count),
        .rename_ready  (rename_ready),
        .src_prn       (src_prn),
        .dest_prn      (dest_prn),
        .old_prn       (old_prn),
        .map_we        (map_we),
        .map_arn       (map_arn),
        .map_new_prn   (map_new_prn),
        .pop_count     (pop_count),
        .invalid_prn   (invalid_prn),
        .fill_push     (fill_push),
        .fill_prn      (fill_prn)
    );

    map_table u_map (
        .clock        (clock),
        .reset        (reset),
        .lookup_arn   (src_arn),
        .lookup_prn   (map_prn),
        .dest_arn     (dest_arn),
        .dest_old_prn (map_old_prn),
        .we           (map_we),
        .wr_arn       (map_arn),
        .wr_prn       (map_new_prn)
    );

    free_list u_free (
        .clock     (clock),
        .reset     (reset),
        .pop_count (pop_count),
        .head_prn  (free_head_prn),
        .push_prn  (push_prn),
        .count     (free_count)
    );

    prf u_prf (
        .clock       (clock),
        .reset       (reset),
        .read_prn    (read_prn),
        .read_data   (read_data),
        .read_valid  (read_valid),
        .write_prn   (write_prn),
        .write_data  (write_data),
        .invalid_prn (invalid_prn),
        .wb_read_prn (wb_read_prn),
        .wb_data     (wb_data)
    );

endmodule

`default_nettype wire

// ==== src/rename_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module rename_ctrl (
    input  logic                                            clock,
    input  logic                                            reset,
    input  logic                                            rename_valid,
    input  rename_pkg::arn_t  [2*rename_pkg::n_ways-1:0]    src_arn,
    input  rename_pkg::arn_t  [rename_pkg::n_ways-1:0]      dest_arn,
    input  rename_pkg::prn_t  [2*rename_pkg::n_ways-1:0]    map_prn,
    input  rename_pkg::prn_t  [rename_pkg::n_ways-1:0]      map_old_prn,
    input  rename_pkg::prn_t  [rename_pkg::n_ways-1:0]      free_head_prn,
    input  rename_pkg::free_cnt_t                           free_count,
    output logic                                            rename_ready,
    output rename_pkg::prn_t  [2*rename_pkg::n_ways-1:0]    src_prn,
    output rename_pkg::prn_t  [rename_pkg::n_ways-1:0]      dest_prn,
    output rename_pkg::prn_t  [rename_pkg::n_ways-1:0]      old_prn,
    output logic              [rename_pkg::n_ways-1:0]      map_we,
    output rename_pkg::arn_t  [rename_pkg::n_ways-1:0]      map_arn,
    output rename_pkg::prn_t  [rename_pkg::n_ways-1:0]      map_new_prn,
    output logic              [1:0]                         pop_count,
    output rename_pkg::prn_t  [rename_pkg::n_ways-1:0]      invalid_prn,
    output logic                                            fill_push,
    output rename_pkg::prn_t                                fill_prn
);

    rename_pkg::ctrl_state_t state_q;
    rename_pkg::prn_t        fill_prn_q;

    logic                                     accept;
    logic             [rename_pkg::n_ways-1:0] has_dest;
    rename_pkg::prn_t [rename_pkg::n_ways-1:0] new_prn;

    // fill the free list with prns arch_reg_sz .. phys_reg_sz-1 after reset
    always_ff @(posedge clock) begin
        if (reset) begin
            state_q    <= rename_pkg::st_fill;
            fill_prn_q <= rename_pkg::prn_t'(rename_pkg::arch_reg_sz);
        end else if (state_q == rename_pkg::st_fill) begin
            fill_prn_q <= fill_prn_q + 1'b1;
            if (fill_prn_q == rename_pkg::prn_t'(rename_pkg::phys_reg_sz - 1)) begin
                state_q <= rename_pkg::st_run;
            end
        end
    end

    assign fill_push = state_q == rename_pkg::st_fill;
    assign fill_prn  = fill_prn_q;

    // need a full group's worth of free prns
    assign rename_ready = state_q == rename_pkg::st_run
                       && free_count >= rename_pkg::free_cnt_t'(rename_pkg::n_ways);
    assign accept       = rename_valid && rename_ready;

    assign has_dest[0] = dest_arn[0] != '0;
    assign has_dest[1] = dest_arn[1] != '0;

    // instruction 1 takes the head when instruction 0 has no destination
    assign new_prn[0] = has_dest[0] ? free_head_prn[0] : '0;
    assign new_prn[1] = !has_dest[1] ? '0
                      : has_dest[0]  ? free_head_prn[1] : free_head_prn[0];

    assign dest_prn = new_prn;

    // forwarding of instruction 0's destination into instruction 1
    always_comb begin
        src_prn[0] = map_prn[0];
        src_prn[1] = map_prn[1];
        for (int j = 2; j < 2 * rename_pkg::n_ways; j++) begin
            if (has_dest[0] && src_arn[j] == dest_arn[0]) begin
                src_prn[j] = new_prn[0];
            end else begin
                src_prn[j] = map_prn[j];
            end
        end
        old_prn[0] = map_old_prn[0];
        if (has_dest[0] && dest_arn[1] == dest_arn[0]) begin
            old_prn[1] = new_prn[0];
        end else begin
            old_prn[1] = map_old_prn[1];
        end
    end

    always_comb begin
        for (int k = 0; k < rename_pkg::n_ways; k++) begin
            map_we[k]      = accept && has_dest[k];
            map_arn[k]     = dest_arn[k];
            map_new_prn[k] = new_prn[k];
            invalid_prn[k] = accept ? new_prn[k] : '0;
        end
        pop_count = accept ? {1'b0, has_dest[0]} + {1'b0, has_dest[1]} : 2'd0;
    end

endmodule

`default_nettype wire

// ==== src/rename_pkg.sv ====
`default_nettype none

package rename_pkg;

    // machine widths
    localparam int n_ways      = 2;
    localparam int arch_reg_sz = 8;
    localparam int phys_reg_sz = 24;
    localparam int free_depth  = phys_reg_sz - arch_reg_sz;
    localparam int data_w      = 16;

    localparam int prn_w      = $clog2(phys_reg_sz);
    localparam int arn_w      = $clog2(arch_reg_sz);
    localparam int free_ptr_w = $clog2(free_depth);
    localparam int free_cnt_w = $clog2(free_depth + 1);

    typedef logic [data_w-1:0]     data_t;
    // prn 0 is the zero register and also means "none" on strobes
    typedef logic [prn_w-1:0]      prn_t;
    typedef logic [arn_w-1:0]      arn_t;
    typedef logic [free_cnt_w-1:0] free_cnt_t;

    // rename controller
    typedef enum logic {
        st_fill,
        st_run
    } ctrl_state_t;

endpackage

`default_nettype wire

// ==== vlog.f ====
src/rename_pkg.sv
src/prf.sv
src/map_table.sv
src/free_list.sv
src/rename_ctrl.sv
src/rename_core.sv
sim/rename_core_chk.sv
sim/rename_core_tb.sv
